/* files.f */
+incdir+include
rtl/cdcFifoPkg.sv
rtl/grayPtrSync.sv
rtl/dualPortRam.sv
rtl/cdcFifoLane.sv
rtl/laneDistributor.sv
rtl/laneCollector.sv
rtl/stripedCdcFifo.sv
dv/tbClockGen.sv
dv/stripedCdcFifoTb.sv

/* dv/stripedCdcFifoTb.sv */
// Testbench for the striped CDC FIFO.
// Seeded random writer on the source clock, queue model of the word order,
// and a monitor on the read clock that checks every output word.

module stripedCdcFifoTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int stallLimit   = 500;     // src cycles a write may wait on full
    localparam int drainLimit   = 3000;    // dst cycles for the model queue to empty
    localparam int fullLowLimit = 1000;    // src cycles for full to fall

    logic                  iSrcClk;
    logic                  iDstClk;
    logic                  arstN;
    logic                  wrEn;
    cdcFifoPkg::fifoWord_t wrData;
    logic                  full;
    logic                  rdValid;
    cdcFifoPkg::fifoWord_t rdData;

    cdcFifoPkg::fifoWord_t model[$];     // words written but not yet seen at the output
    integer                seed;
    string                 testName;
    int                    fullStalls;   // write cycles held off by full

    // ----------------------------------------
    // clocks and DUT
    // ----------------------------------------
    tbClockGen #(.period(7.0))  uSrcClkGen (.clk(iSrcClk));
    tbClockGen #(.period(10.0)) uDstClkGen (.clk(iDstClk));

    stripedCdcFifo UUT (
        .iSrcClk(iSrcClk), .iDstClk(iDstClk), .arstN(arstN),
        .wrEn(wrEn), .wrData(wrData), .full(full),
        .rdValid(rdValid), .rdData(rdData)
    );

    // ----------------------------------------
    // error handling and compares
    // ----------------------------------------
    task automatic stopOnError();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR in %s: %s", testName, what);
        stopOnError();
    endtask

    task automatic checkWord(input string name, input cdcFifoPkg::fifoWord_t expected,
                             input cdcFifoPkg::fifoWord_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            stopOnError();
        end
    endtask

    // ----------------------------------------
    // output monitor pops the model
    // ----------------------------------------
    always @(posedge iDstClk)
    begin
        if (arstN && rdValid)
        begin
            if (model.size() == 0)
                reportProblem("rdValid with no word outstanding, word duplicated");
            else
                checkWord(testName, model.pop_front(), rdData);   // oldest word first
        end
    end

    // ----------------------------------------
    // writer and wait helpers
    // ----------------------------------------
    // writes count words with random idle gaps of 0..maxGap cycles
    // never writes while full
    task automatic writeBurst(input int count, input int maxGap);
        int                    sent;
        int                    gapLeft;
        int                    stall;
        cdcFifoPkg::fifoWord_t word;
        sent    = 0;
        gapLeft = 0;
        stall   = 0;
        while (sent < count)
        begin
            @(posedge iSrcClk);
            if (gapLeft > 0)
            begin
                wrEn <= 1'b0;
                gapLeft--;
            end
            else if (full)   // full as left by the previous edge
            begin
                wrEn <= 1'b0;
                stall++;
                fullStalls++;
                if (stall > stallLimit)
                    reportProblem("timeout waiting for full to fall during a burst");
            end
            else
            begin
                word = cdcFifoPkg::fifoWord_t'($random(seed));
                wrEn   <= 1'b1;
                wrData <= word;
                model.push_back(word);
                sent++;
                stall = 0;
                if (maxGap > 0)
                    gapLeft = $unsigned($random(seed)) % (maxGap + 1);
            end
        end
        @(posedge iSrcClk);
        wrEn <= 1'b0;
    endtask

    // sampled on the falling edge away from the monitor's pops
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (model.size() != 0)
        begin
            @(negedge iDstClk);
            cycles++;
            if (cycles > drainLimit)
                reportProblem("timeout waiting for every written word to come out");
        end
    endtask

    task automatic waitFullLow();
        int cycles;
        cycles = 0;
        while (full)
        begin
            @(negedge iSrcClk);
            cycles++;
            if (cycles > fullLowLimit)
                reportProblem("timeout waiting for full to fall after the drain");
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        seed       = 32'h24e9;
        arstN      = 1'b0;
        wrEn       = 1'b0;
        wrData     = '0;
        testName   = "reset";
        fullStalls = 0;

        // flags low while in reset
        for (int i = 0; i < 10; i++)
        begin
            @(negedge iDstClk);
            checkFlag("reset rdValid", 1'b0, rdValid);
            checkFlag("reset full", 1'b0, full);
        end
        @(posedge iDstClk);
        arstN <= 1'b1;
        // and still low once the synchronized resets let go
        for (int i = 0; i < 10; i++)
        begin
            @(negedge iDstClk);
            checkFlag("after reset rdValid", 1'b0, rdValid);
            checkFlag("after reset full", 1'b0, full);
        end

        testName = "ordered transfer";
        writeBurst(200, 3);    // 50 per lane wraps every lane pointer
        waitDrain();

        testName   = "full back-pressure";
        fullStalls = 0;
        writeBurst(300, 0);    // long enough for the writes to outrun the read clock
        checkFlag("full back-pressure full seen", 1'b1, fullStalls > 0);
        waitFullLow();

        testName = "drain";
        waitDrain();
        for (int i = 0; i < 50; i++)
        begin
            @(negedge iDstClk);
            checkFlag("drain rdValid", 1'b0, rdValid);   // nothing left in flight
        end

        testName = "sparse traffic";
        for (int i = 0; i < 8; i++)   // two lone words per lane
        begin
            writeBurst(1, 0);
            waitDrain();
            repeat (40) @(posedge iSrcClk);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* dv/tbClockGen.sv */
// Testbench clock generator.
// Free-running square wave, starts low, one instance per clock domain.

module tbClockGen #(
    parameter real period = 10.0    // ns
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // toggle every half period
    // ----------------------------------------
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period / 2.0) clk = ~clk;   // first rise at half period
        end
    end

endmodule

/* rtl/stripedCdcFifo.sv */
// Striped clock-domain-crossing FIFO, top level.
// Deals a word stream over four async FIFO lanes and rebuilds it in order
// on the read clock. Reset is synchronized separately into each domain.
`include "cdcFifo_defs.svh"

module stripedCdcFifo (
    input  logic                  iSrcClk,
    input  logic                  iDstClk,
    input  logic                  arstN,
    input  logic                  wrEn,
    input  cdcFifoPkg::fifoWord_t wrData,
    output logic                  full,
    output logic                  rdValid,
    output cdcFifoPkg::fifoWord_t rdData
);

    logic [1:0]                  srcRstPipe;
    logic [1:0]                  dstRstPipe;
    logic                        srcRstN;
    logic                        dstRstN;
    cdcFifoPkg::laneWr_t         laneWr [`FIFO_NUM_LANES];
    cdcFifoPkg::laneRd_t         laneRd [`FIFO_NUM_LANES];
    logic [`FIFO_NUM_LANES-1:0]  laneFull;
    logic [`FIFO_NUM_LANES-1:0]  laneEmpty;
    logic [`FIFO_NUM_LANES-1:0]  laneRdEn;

    // ----------------------------------------
    // reset sync, async assert, sync release
    // ----------------------------------------
    always_ff @(posedge iSrcClk or negedge arstN)
    begin
        if (!arstN)
            srcRstPipe <= '0;
        else
            srcRstPipe <= {srcRstPipe[0], 1'b1};
    end

    always_ff @(posedge iDstClk or negedge arstN)
    begin
        if (!arstN)
            dstRstPipe <= '0;
        else
            dstRstPipe <= {dstRstPipe[0], 1'b1};
    end

    assign srcRstN = srcRstPipe[1];
    assign dstRstN = dstRstPipe[1];

    // ----------------------------------------
    // distributor, lanes, collector
    // ----------------------------------------
    laneDistributor uDistributor (
        .iSrcClk(iSrcClk), .srcRstN(srcRstN), .wrEn(wrEn), .wrData(wrData),
        .laneFull(laneFull), .laneWr(laneWr), .full(full)
    );

    for (genvar g = 0; g < `FIFO_NUM_LANES; g++)
    begin : gLane
        cdcFifoLane uLane (
            .iSrcClk(iSrcClk), .iDstClk(iDstClk), .srcRstN(srcRstN), .dstRstN(dstRstN),
            .wr(laneWr[g]), .full(laneFull[g]),
            .rdEn(laneRdEn[g]), .empty(laneEmpty[g]), .rd(laneRd[g])
        );
    end

    laneCollector uCollector (
        .iDstClk(iDstClk), .dstRstN(dstRstN), .laneEmpty(laneEmpty), .laneRd(laneRd),
        .laneRdEn(laneRdEn), .rdValid(rdValid), .rdData(rdData)
    );

endmodule

/* rtl/laneCollector.sv */
// Read-domain lane collector.
// Drains the lanes in the same round-robin order as the writes were dealt,
// and merges the returning lane results into one registered output stream.
`include "cdcFifo_defs.svh"

module laneCollector (
    input  logic                        iDstClk,
    input  logic                        dstRstN,
    input  logic [`FIFO_NUM_LANES-1:0]  laneEmpty,
    input  cdcFifoPkg::laneRd_t         laneRd [`FIFO_NUM_LANES],
    output logic [`FIFO_NUM_LANES-1:0]  laneRdEn,    // one-hot read strobes
    output logic                        rdValid,
    output cdcFifoPkg::fifoWord_t       rdData
);

    cdcFifoPkg::laneIdx_t        rdIdx;       // lane holding the next word in order
    logic                        issue;
    logic [`FIFO_NUM_LANES-1:0]  laneVld;
    cdcFifoPkg::fifoWord_t       mergeData;

    // ----------------------------------------
    // issue side
    // ----------------------------------------
    assign issue = !laneEmpty[rdIdx];   // wait here until the ordered lane has data

    always_comb
    begin
        laneRdEn        = '0;
        laneRdEn[rdIdx] = issue;
    end

    always_ff @(posedge iDstClk or negedge dstRstN)
    begin
        if (!dstRstN)
            rdIdx <= '0;
        else if (issue)
        begin
            if (rdIdx == cdcFifoPkg::laneIdx_t'(`FIFO_NUM_LANES - 1))
                rdIdx <= '0;
            else
                rdIdx <= rdIdx + 1'b1;
        end
    end

    // ----------------------------------------
    // merge side
    // ----------------------------------------
    // equal lane latency keeps results in issue order
    always_comb
    begin
        mergeData = '0;
        for (int i = 0; i < `FIFO_NUM_LANES; i++)
        begin
            laneVld[i] = laneRd[i].valid;
            if (laneRd[i].valid)
                mergeData = mergeData | laneRd[i].data;   // at most one term
        end
    end

    always_ff @(posedge iDstClk or negedge dstRstN)
    begin
        if (!dstRstN)
            rdValid <= 1'b0;
        else
            rdValid <= |laneVld;
    end

    always_ff @(posedge iDstClk)
    begin
        rdData <= mergeData;    // don't care while rdValid low
    end

    // one read per cycle and equal latency in every lane
    aOneVld : assert property (@(posedge iDstClk) disable iff (!dstRstN) $onehot0(laneVld))
        else $error("two lanes returned data in the same cycle");

endmodule

/* rtl/laneDistributor.sv */
// Write-domain lane distributor.
// Deals incoming words round-robin to the lanes and presents the full
// level of the lane that takes the next write.
`include "cdcFifo_defs.svh"

module laneDistributor (
    input  logic                        iSrcClk,
    input  logic                        srcRstN,
    input  logic                        wrEn,
    input  cdcFifoPkg::fifoWord_t       wrData,
    input  logic [`FIFO_NUM_LANES-1:0]  laneFull,
    output cdcFifoPkg::laneWr_t         laneWr [`FIFO_NUM_LANES],
    output logic                        full       // full of the current lane
);

    cdcFifoPkg::laneIdx_t wrIdx;   // lane for the next write

    // ----------------------------------------
    // round-robin write index
    // ----------------------------------------
    always_ff @(posedge iSrcClk or negedge srcRstN)
    begin
        if (!srcRstN)
            wrIdx <= '0;
        else if (wrEn)
        begin
            if (wrIdx == cdcFifoPkg::laneIdx_t'(`FIFO_NUM_LANES - 1))
                wrIdx <= '0;                     // wrap to lane 0
            else
                wrIdx <= wrIdx + 1'b1;
        end
    end

    // ----------------------------------------
    // steering
    // ----------------------------------------
    always_comb
    begin
        for (int i = 0; i < `FIFO_NUM_LANES; i++)
        begin
            laneWr[i].wrEn = wrEn && (wrIdx == cdcFifoPkg::laneIdx_t'(i));  // only one strobes
            laneWr[i].data = wrData;                                       // word fans out
        end
    end

    assign full = laneFull[wrIdx];

endmodule

/* rtl/cdcFifoLane.sv */
// One asynchronous FIFO lane.
// Binary and gray pointers in each domain, gray crossing through two
// synchronizers, registered empty and early full flags, and a fixed
// two-cycle read pipeline from accepted read to valid data.
`include "cdcFifo_defs.svh"

module cdcFifoLane (
    input  logic                iSrcClk,
    input  logic                iDstClk,
    input  logic                srcRstN,
    input  logic                dstRstN,
    input  cdcFifoPkg::laneWr_t wr,       // write strobe and word
    output logic                full,     // early full, margin entries left
    input  logic                rdEn,     // read request from collector
    output logic                empty,
    output cdcFifoPkg::laneRd_t rd        // valid pulse and word
);

    // write domain
    cdcFifoPkg::lanePtr_t wrPtrBin;
    cdcFifoPkg::lanePtr_t wrPtrNext;
    cdcFifoPkg::lanePtr_t wrPtrGray;
    cdcFifoPkg::lanePtr_t rdPtrSync;     // read pointer as seen on src side
    cdcFifoPkg::lanePtr_t wrLevel;       // words held, pessimistic
    cdcFifoPkg::lanePtr_t wrLevelNext;
    logic                 wrAcc;
    logic                 noRoom;        // all entries taken
    logic                 fullQ;

    // read domain
    cdcFifoPkg::lanePtr_t rdPtrBin;
    cdcFifoPkg::lanePtr_t rdPtrNext;
    cdcFifoPkg::lanePtr_t rdPtrGray;
    cdcFifoPkg::lanePtr_t wrPtrSync;     // write pointer as seen on dst side
    logic                 rdAcc;
    logic                 emptyQ;
    logic [`FIFO_READ_LATENCY-1:0] rdVldPipe;
    cdcFifoPkg::fifoWord_t ramData;
    cdcFifoPkg::fifoWord_t rdDataQ;

    // ----------------------------------------
    // write side
    // ----------------------------------------
    assign wrLevel     = cdcFifoPkg::lanePtr_t'(wrPtrBin - rdPtrSync);
    assign noRoom      = (wrLevel == cdcFifoPkg::lanePtr_t'(`FIFO_LANE_DEPTH));
    assign wrAcc       = wr.wrEn && !noRoom;     // overflow is dropped
    assign wrPtrNext   = wrPtrBin + cdcFifoPkg::lanePtr_t'(wrAcc);
    assign wrLevelNext = cdcFifoPkg::lanePtr_t'(wrPtrNext - rdPtrSync);

    always_ff @(posedge iSrcClk or negedge srcRstN)
    begin
        if (!srcRstN)
        begin
            wrPtrBin  <= '0;
            wrPtrGray <= '0;
            fullQ     <= 1'b0;
        end
        else
        begin
            wrPtrBin  <= wrPtrNext;
            wrPtrGray <= wrPtrNext ^ (wrPtrNext >> 1);   // one bit flips per step
            fullQ     <= (wrLevelNext >= (`FIFO_LANE_DEPTH - `FIFO_FULL_MARGIN));
        end
    end

    assign full = fullQ;

    // ----------------------------------------
    // read side
    // ----------------------------------------
    assign rdAcc     = rdEn && !emptyQ;          // reads on empty ignored
    assign rdPtrNext = rdPtrBin + cdcFifoPkg::lanePtr_t'(rdAcc);

    always_ff @(posedge iDstClk or negedge dstRstN)
    begin
        if (!dstRstN)
        begin
            rdPtrBin  <= '0;
            rdPtrGray <= '0;
            emptyQ    <= 1'b1;
            rdVldPipe <= '0;
        end
        else
        begin
            rdPtrBin  <= rdPtrNext;
            rdPtrGray <= rdPtrNext ^ (rdPtrNext >> 1);
            emptyQ    <= (rdPtrNext == wrPtrSync);   // exact against stale wr ptr
            rdVldPipe <= {rdVldPipe[`FIFO_READ_LATENCY-2:0], rdAcc};
        end
    end

    // second latency stage, lines up with rdVldPipe msb
    always_ff @(posedge iDstClk)
    begin
        rdDataQ <= ramData;
    end

    assign empty = emptyQ;
    assign rd    = '{valid: rdVldPipe[`FIFO_READ_LATENCY-1], data: rdDataQ};

    // ----------------------------------------
    // storage and pointer crossings
    // ----------------------------------------
    dualPortRam uRam (
        .iSrcClk (iSrcClk),
        .wrEn    (wrAcc),
        .wrAddr  (wrPtrBin[`FIFO_ADDR_WIDTH-1:0]),
        .wrData  (wr.data),
        .iDstClk (iDstClk),
        .rdAddr  (rdPtrBin[`FIFO_ADDR_WIDTH-1:0]),
        .rdData  (ramData)
    );

    grayPtrSync uWrPtrSync (.dstClk(iDstClk), .rstN(dstRstN), .ptrGray(wrPtrGray), .ptrBin(wrPtrSync));
    grayPtrSync uRdPtrSync (.dstClk(iSrcClk), .rstN(srcRstN), .ptrGray(rdPtrGray), .ptrBin(rdPtrSync));

    // margin must absorb the writer's late look at full and the round-robin slack
    aWrRoom : assert property (@(posedge iSrcClk) disable iff (!srcRstN) wr.wrEn |-> !noRoom)
        else $error("lane overflow, write dropped");

    // collector must only read a lane it has seen non-empty
    aRdEmpty : assert property (@(posedge iDstClk) disable iff (!dstRstN) rdEn |-> !emptyQ)
        else $error("read enable while lane empty");

endmodule

/* rtl/dualPortRam.sv */
// Lane storage array.
// Simple dual-port memory, written on the source clock and read through an
// output register on the destination clock.
`include "cdcFifo_defs.svh"

module dualPortRam (
    input  logic                       iSrcClk,
    input  logic                       wrEn,
    input  logic [`FIFO_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`FIFO_DATA_WIDTH-1:0] wrData,
    input  logic                       iDstClk,
    input  logic [`FIFO_ADDR_WIDTH-1:0] rdAddr,
    output logic [`FIFO_DATA_WIDTH-1:0] rdData    // one dst cycle after rdAddr
);

    logic [`FIFO_DATA_WIDTH-1:0] mem [`FIFO_LANE_DEPTH];

    // write port
    always_ff @(posedge iSrcClk)
    begin
        if (wrEn)
            mem[wrAddr] <= wrData;
    end

    // ----------------------------------------
    // read port, free running
    // ----------------------------------------
    // first of the two read latency cycles; the lane only
    // looks at the result when the address was a real read
    always_ff @(posedge iDstClk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

/* rtl/grayPtrSync.sv */
// Gray pointer synchronizer.
// Brings one gray-coded lane pointer into the receiving clock domain through
// two flops, then converts it to binary in a registered stage.
`include "cdcFifo_defs.svh"

module grayPtrSync (
    input  logic                      dstClk,    // receiving clock, src or dst
    input  logic                      rstN,      // reset of the receiving domain
    input  logic [`FIFO_ADDR_WIDTH:0] ptrGray,   // from the sending domain
    output logic [`FIFO_ADDR_WIDTH:0] ptrBin     // binary, receiving domain
);

    logic [`FIFO_ADDR_WIDTH:0] syncQ1;    // may go metastable
    logic [`FIFO_ADDR_WIDTH:0] syncQ2;    // settled
    logic [`FIFO_ADDR_WIDTH:0] binComb;

    // ----------------------------------------
    // two-flop capture, then binary register
    // ----------------------------------------
    always_ff @(posedge dstClk or negedge rstN)
    begin
        if (!rstN)
        begin
            syncQ1 <= '0;
            syncQ2 <= '0;
            ptrBin <= '0;
        end
        else
        begin
            syncQ1 <= ptrGray;
            syncQ2 <= syncQ1;
            ptrBin <= binComb;
        end
    end

    // gray to binary, msb down
    always_comb
    begin
        binComb[`FIFO_ADDR_WIDTH] = syncQ2[`FIFO_ADDR_WIDTH];
        for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--)
            binComb[i] = binComb[i+1] ^ syncQ2[i];   // running xor of upper bits
    end

endmodule

/* rtl/cdcFifoPkg.sv */
// Striped CDC FIFO types.
// Word, pointer and lane index vectors plus the lane transfer structs.
`include "cdcFifo_defs.svh"

package cdcFifoPkg;

    typedef logic [`FIFO_DATA_WIDTH-1:0] fifoWord_t;             // one stream word
    typedef logic [`FIFO_ADDR_WIDTH:0] lanePtr_t;                // binary or gray, with wrap bit
    typedef logic [$clog2(`FIFO_NUM_LANES)-1:0] laneIdx_t;       // lane number

    // one write, distributor to lane
    typedef struct packed {
        logic      wrEn;    // write strobe
        fifoWord_t data;
    } laneWr_t;

    // one read result, lane to collector
    typedef struct packed {
        logic      valid;   // single-cycle pulse
        fifoWord_t data;
    } laneRd_t;

endpackage

/* include/cdcFifo_defs.svh */
// Striped CDC FIFO global sizes.
// Lane geometry, lane count and flag timing shared by all blocks.
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// ----------------------------------------
// data path
// ----------------------------------------
`define FIFO_DATA_WIDTH   24    // bits per word
`define FIFO_NUM_LANES    4     // round-robin stripes

// ----------------------------------------
// per-lane storage and flags
// ----------------------------------------
`define FIFO_LANE_DEPTH   16    // words per lane
`define FIFO_ADDR_WIDTH   4     // ram address, pointers carry one more wrap bit
`define FIFO_FULL_MARGIN  3     // free entries left when full rises
`define FIFO_READ_LATENCY 2     // dst cycles from accepted read to valid

`endif
